/* rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path and instruction widths
`define RV_XLEN 64
`define RV_ILEN 32

// Architectural integer registers, x0 included
`define RV_REG_COUNT 32

// Instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 256

// Data memory size in bytes
// Byte addresses wrap modulo this size, so it must be a power of two
`define RV_DMEM_BYTES 1024

`endif

/* rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

    // Register and data path value
    typedef logic [`RV_XLEN-1:0] xlen_t;

    // Raw instruction word
    typedef logic [`RV_ILEN-1:0] inst_t;

    // Register number, x0 to x31
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

    // Operation selector shared by ALU, branch and load/store paths
    typedef logic [2:0] funct3_t;

    // Word index into instruction memory
    typedef logic [$clog2(`RV_IMEM_WORDS)-1:0] imem_idx_t;

    // Instruction memory load handshake
    typedef enum logic {
        load_idle,
        load_acked
    } load_state_e;

endpackage

/* fetch_unit.sv */
`include "rv_defines.svh"

module fetch_unit import rv_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      run,
    input  xlen_t     next_pc,
    input  logic      illegal,
    input  logic      load_req,
    input  imem_idx_t load_addr,
    input  inst_t     load_word,
    output logic      load_ack,
    output xlen_t     pc,
    output inst_t     instr,
    output logic      halted
);

    localparam int IDX_W = $bits(imem_idx_t);

    inst_t       imem [`RV_IMEM_WORDS];
    load_state_e load_state;
    logic        exec_en;
    logic        load_write;

    assign exec_en    = run && !halted;
    assign load_write = !run && load_req && (load_state == load_idle);
    assign load_ack   = (load_state == load_acked);
    assign instr      = imem[pc[IDX_W+1:2]]; // Word at pc / 4

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (exec_en) begin
            if (illegal) begin
                halted <= 1'b1; // pc stays on the bad word
            end else begin
                pc <= next_pc;
            end
        end
    end

    // Four-phase handshake, one write per request
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            load_state <= load_idle;
        end else begin
            case (load_state)
                load_idle: begin
                    if (load_write) begin
                        load_state <= load_acked;
                    end
                end
                load_acked: begin
                    if (!load_req) begin
                        load_state <= load_idle;
                    end
                end
                default: load_state <= load_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (load_write) begin
            imem[load_addr] <= load_word;
        end
    end

endmodule

/* instr_decoder.sv */
module instr_decoder import rv_pkg::*; (
    input  inst_t    instr,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output funct3_t  funct3,
    output logic     alt_op,
    output xlen_t    imm,
    output logic     use_imm,
    output logic     reg_write,
    output logic     [1:0] wb_sel,
    output logic     add_pc_to_upper,
    output logic     is_branch,
    output logic     is_jal,
    output logic     is_jalr,
    output logic     mem_read,
    output logic     mem_write,
    output logic     illegal
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    logic       valid;
    logic       writes_rd;

    assign opcode = instr[6:0];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct3 = instr[14:12];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        valid           = 1'b0;
        writes_rd       = 1'b0;
        imm             = imm_i;
        use_imm         = 1'b0;
        alt_op          = 1'b0;
        wb_sel          = 2'd0; // ALU result
        add_pc_to_upper = 1'b0;
        is_branch       = 1'b0;
        is_jal          = 1'b0;
        is_jalr         = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;

        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                valid           = 1'b1;
                writes_rd       = 1'b1;
                imm             = imm_u;
                wb_sel          = 2'd3;
                add_pc_to_upper = (opcode == OPC_AUIPC);
            end
            OPC_JAL: begin
                valid     = 1'b1;
                writes_rd = 1'b1;
                imm       = imm_j;
                wb_sel    = 2'd2; // Link
                is_jal    = 1'b1;
            end
            OPC_JALR: begin
                valid     = (funct3 == 3'b000);
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                wb_sel    = 2'd2;
                is_jalr   = 1'b1;
            end
            OPC_BRANCH: begin
                valid     = (funct3[2:1] != 2'b01); // 010 and 011 unused
                imm       = imm_b;
                is_branch = 1'b1;
            end
            OPC_LOAD: begin
                valid     = (funct3 != 3'b111);
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                wb_sel    = 2'd1;
                mem_read  = 1'b1;
            end
            OPC_STORE: begin
                valid     = !funct3[2];
                imm       = imm_s;
                use_imm   = 1'b1;
                mem_write = valid;
            end
            OPC_OP_IMM: begin
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                case (funct3)
                    3'b001:  valid = (instr[31:26] == 6'b000000);
                    3'b101:  valid = (instr[31:26] == 6'b000000) || (instr[31:26] == 6'b010000);
                    default: valid = 1'b1;
                endcase
                alt_op = (funct3 == 3'b101) && instr[30]; // SRAI only
            end
            OPC_OP: begin
                writes_rd = 1'b1;
                valid     = (funct7 == 7'b0000000) ||
                            ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
                alt_op    = instr[30]; // SUB and SRA
            end
            default: valid = 1'b0;
        endcase
    end

    // An illegal word must not touch state
    assign illegal   = !valid;
    assign reg_write = valid && writes_rd;

endmodule

/* reg_file.sv */
`include "rv_defines.svh"

module reg_file import rv_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t dbg_reg,
    input  reg_idx_t rd,
    input  logic     write_en,
    input  xlen_t    write_data,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    output xlen_t    dbg_value
);

    xlen_t regs [`RV_REG_COUNT];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd != '0)) begin // x0 stays zero
            regs[rd] <= write_data;
        end
    end

    assign rs1_data  = regs[rs1];
    assign rs2_data  = regs[rs2];
    assign dbg_value = regs[dbg_reg];

endmodule

/* alu.sv */
`include "rv_defines.svh"

module alu import rv_pkg::*; (
    input  xlen_t   operand_a,
    input  xlen_t   operand_b,
    input  funct3_t funct3,
    input  logic    alt_op,
    output xlen_t   result
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = operand_b[SHAMT_W-1:0];
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (funct3)
            3'b000: begin
                if (alt_op) begin
                    result = operand_a - operand_b;
                end else begin
                    result = operand_a + operand_b; // Also address add
                end
            end
            3'b001: result = operand_a << shamt;
            3'b010: result = xlen_t'(lt_signed);
            3'b011: result = xlen_t'(lt_unsigned);
            3'b100: result = operand_a ^ operand_b;
            3'b101: begin
                if (alt_op) begin
                    result = xlen_t'($signed(operand_a) >>> shamt);
                end else begin
                    result = operand_a >> shamt;
                end
            end
            3'b110: result = operand_a | operand_b;
            3'b111: result = operand_a & operand_b;
            default: result = '0;
        endcase
    end

endmodule

/* branch_unit.sv */
module branch_unit import rv_pkg::*; (
    input  xlen_t   pc,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    input  xlen_t   imm,
    input  xlen_t   alu_result,
    input  funct3_t funct3,
    input  logic    is_branch,
    input  logic    is_jal,
    input  logic    is_jalr,
    output xlen_t   next_pc
);

    logic cond;

    always_comb begin
        case (funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  cond = rs1_data < rs2_data;
            3'b111:  cond = rs1_data >= rs2_data;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        if (is_jalr) begin
            next_pc = {alu_result[$bits(xlen_t)-1:1], 1'b0};
        end else if (is_jal || (is_branch && cond)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + xlen_t'(4);
        end
    end

endmodule

/* load_store_unit.sv */
`include "rv_defines.svh"

module load_store_unit import rv_pkg::*; (
    input  logic    clock,
    input  xlen_t   address,
    input  xlen_t   store_data,
    input  funct3_t funct3,
    input  logic    mem_write,
    output xlen_t   load_data
);

    localparam int ADDR_W = $clog2(`RV_DMEM_BYTES);

    logic [7:0]        dmem [`RV_DMEM_BYTES];
    logic [ADDR_W-1:0] base;
    logic [3:0]        num_bytes;
    xlen_t             raw;

    assign base      = address[ADDR_W-1:0]; // Wraps modulo memory size
    assign num_bytes = 4'd1 << funct3[1:0];

    // Little-endian byte lanes
    always_ff @(posedge clock) begin
        if (mem_write) begin
            for (int i = 0; i < 8; i++) begin
                if (i < num_bytes) begin
                    dmem[base + ADDR_W'(i)] <= store_data[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            raw[8*i +: 8] = dmem[base + ADDR_W'(i)];
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  load_data = {{56{raw[7]}}, raw[7:0]};
            3'b001:  load_data = {{48{raw[15]}}, raw[15:0]};
            3'b010:  load_data = {{32{raw[31]}}, raw[31:0]};
            3'b100:  load_data = {56'b0, raw[7:0]};
            3'b101:  load_data = {48'b0, raw[15:0]};
            3'b110:  load_data = {32'b0, raw[31:0]};
            default: load_data = raw; // LD
        endcase
    end

endmodule

/* rv_core_top.sv */
module rv_core_top import rv_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      run,
    input  logic      load_req,
    input  imem_idx_t load_addr,
    input  inst_t     load_word,
    output logic      load_ack,
    input  reg_idx_t  dbg_reg,
    output xlen_t     dbg_value,
    output xlen_t     pc,
    output logic      halted
);

    inst_t    instr;
    xlen_t    next_pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    funct3_t  funct3;
    funct3_t  alu_funct3;
    logic     alt_op;
    xlen_t    imm;
    logic     use_imm;
    logic     reg_write;
    logic     [1:0] wb_sel;
    logic     add_pc_to_upper;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    logic     mem_read;
    logic     mem_write;
    logic     illegal;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    operand_b;
    xlen_t    alu_result;
    xlen_t    load_data;
    xlen_t    wb_data;
    logic     exec_en;

    assign exec_en = run && !halted;

    fetch_unit u_fetch (
        .clock     (clock),
        .reset_n   (reset_n),
        .run       (run),
        .next_pc   (next_pc),
        .illegal   (illegal),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_word (load_word),
        .load_ack  (load_ack),
        .pc        (pc),
        .instr     (instr),
        .halted    (halted)
    );

    instr_decoder u_decoder (
        .instr           (instr),
        .rs1             (rs1),
        .rs2             (rs2),
        .rd              (rd),
        .funct3          (funct3),
        .alt_op          (alt_op),
        .imm             (imm),
        .use_imm         (use_imm),
        .reg_write       (reg_write),
        .wb_sel          (wb_sel),
        .add_pc_to_upper (add_pc_to_upper),
        .is_branch       (is_branch),
        .is_jal          (is_jal),
        .is_jalr         (is_jalr),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .illegal         (illegal)
    );

    reg_file u_regs (
        .clock      (clock),
        .reset_n    (reset_n),
        .rs1        (rs1),
        .rs2        (rs2),
        .dbg_reg    (dbg_reg),
        .rd         (rd),
        .write_en   (reg_write && exec_en),
        .write_data (wb_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dbg_value  (dbg_value)
    );

    assign operand_b  = use_imm ? imm : rs2_data;
    assign alu_funct3 = (mem_read || mem_write || is_jalr) ? 3'b000 : funct3; // Address add

    alu u_alu (
        .operand_a (rs1_data),
        .operand_b (operand_b),
        .funct3    (alu_funct3),
        .alt_op    (alt_op),
        .result    (alu_result)
    );

    branch_unit u_branch (
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .alu_result (alu_result),
        .funct3     (funct3),
        .is_branch  (is_branch),
        .is_jal     (is_jal),
        .is_jalr    (is_jalr),
        .next_pc    (next_pc)
    );

    load_store_unit u_lsu (
        .clock      (clock),
        .address    (alu_result),
        .store_data (rs2_data),
        .funct3     (funct3),
        .mem_write  (mem_write && exec_en),
        .load_data  (load_data)
    );

    always_comb begin
        case (wb_sel)
            2'd1:    wb_data = load_data;
            2'd2:    wb_data = pc + xlen_t'(4); // Link address
            2'd3:    wb_data = add_pc_to_upper ? pc + imm : imm;
            default: wb_data = alu_result;
        endcase
    end

endmodule

/* tb_rv_core.sv */
module tb_rv_core import rv_pkg::*;;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 6;
    localparam int WORDS_BOUND     = 150; // All programs together, end words included
    localparam int CYCLES_PER_WORD = 3;   // Two handshake edges plus execution
    localparam int TEST_OVERHEAD   = 50;  // Reset and register read-back
    localparam int WATCHDOG_CYCLES =
        2 * (WORDS_BOUND * CYCLES_PER_WORD + NUM_TESTS * TEST_OVERHEAD);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // Bit 3 is alt_op, bits 2:0 are funct3
    localparam logic [3:0] REG_OPS [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3,
                                            4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    localparam logic [3:0] IMM_OPS [9]  = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6,
                                            4'h7, 4'h1, 4'h5, 4'hd};
    localparam logic [2:0] BR_F3 [6]    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic      clock;
    logic      reset_n;
    logic      run;
    logic      load_req;
    imem_idx_t load_addr;
    inst_t     load_word;
    logic      load_ack;
    reg_idx_t  dbg_reg;
    xlen_t     dbg_value;
    xlen_t     pc;
    logic      halted;

    int        errors;
    string     test_name;
    inst_t     prog [$];
    xlen_t     exp_val [32];
    bit        exp_on [32];
    logic [7:0] mem_bytes [16]; // Model of the bytes at the store base

    rv_core_top dut (
        .clock     (clock),
        .reset_n   (reset_n),
        .run       (run),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_word (load_word),
        .load_ack  (load_ack),
        .dbg_reg   (dbg_reg),
        .dbg_value (dbg_value),
        .pc        (pc),
        .halted    (halted)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    funct3_t f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_t f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic inst_t enc_b(logic [12:0] off, reg_idx_t rs1, reg_idx_t rs2,
                                    funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t enc_j(logic [20:0] off, reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic xlen_t sext12(logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic xlen_t sext_upper(logic [19:0] u);
        return {{32{u[19]}}, u, 12'b0};
    endfunction

    // RV64I semantics of the OP and OP-IMM group
    function automatic xlen_t ref_alu(funct3_t f3, logic alt, xlen_t a, xlen_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: return (a < b) ? 64'd1 : 64'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit ref_taken(funct3_t f3, xlen_t a, xlen_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Little-endian read from the byte model, then sign or zero extension
    function automatic xlen_t ref_load(int off, funct3_t f3);
        xlen_t raw;
        int    n;
        raw = '0;
        n   = 1 << f3[1:0];
        for (int i = 0; i < n; i++) begin
            raw[8*i +: 8] = mem_bytes[off + i];
        end
        if (!f3[2] && n < 8 && raw[8*n-1]) begin
            raw = raw | (~xlen_t'(0) << (8 * n));
        end
        return raw;
    endfunction

    task automatic check_value(string what, xlen_t exp, xlen_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic fail_plain(string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic set_expected(int r, xlen_t v);
        exp_on[r]  = 1'b1;
        exp_val[r] = v;
    endtask

    task automatic begin_test(string name);
        test_name = name;
        prog.delete();
        for (int r = 0; r < 32; r++) begin
            exp_on[r] = 1'b0;
        end
        @(negedge clock);
        reset_n  = 1'b0;
        run      = 1'b0;
        load_req = 1'b0;
        repeat (5) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_value("pc after reset", '0, pc);
        if (halted || load_ack) begin
            fail_plain("halted or load_ack is high after reset");
        end
    endtask

    // Four-phase handshake, entered and left on a falling edge
    task automatic load_word_task(imem_idx_t addr, inst_t word);
        int waited;
        load_addr = addr;
        load_word = word;
        load_req  = 1'b1;
        waited    = 0;
        while (!load_ack && waited < 4) begin
            @(negedge clock);
            waited++;
        end
        if (!load_ack) begin
            fail_plain($sformatf("load_ack never rose for word %0d", addr));
        end
        load_req = 1'b0;
        waited   = 0;
        while (load_ack && waited < 4) begin
            @(negedge clock);
            waited++;
        end
        if (load_ack) begin
            fail_plain($sformatf("load_ack never fell for word %0d", addr));
        end
    endtask

    task automatic add_const(int rd, output xlen_t value);
        logic [19:0] hi;
        logic [11:0] lo;
        hi = 20'($urandom);
        lo = 12'($urandom);
        prog.push_back(enc_u(hi, reg_idx_t'(rd), OPC_LUI));
        prog.push_back(enc_i(lo, reg_idx_t'(rd), 3'd0, reg_idx_t'(rd), OPC_OP_IMM));
        value = sext_upper(hi) + sext12(lo);
    endtask

    task automatic execute_and_check();
        int waited;
        for (int i = 0; i < prog.size(); i++) begin
            load_word_task(imem_idx_t'(i), prog[i]);
        end
        load_word_task(imem_idx_t'(prog.size()), '0); // End word
        run    = 1'b1;
        waited = 0;
        while (!halted && waited < prog.size() + 8) begin
            @(negedge clock);
            waited++;
        end
        if (!halted) begin
            fail_plain("core did not halt at the end word");
        end
        check_value("pc at end word", xlen_t'(4 * prog.size()), pc);
        run = 1'b0;
        for (int r = 0; r < 32; r++) begin
            if (exp_on[r]) begin
                dbg_reg = reg_idx_t'(r);
                #10;
                check_value($sformatf("x%0d", r), exp_val[r], dbg_value);
                @(negedge clock);
            end
        end
    endtask

    task automatic test_program_load();
        begin_test("program_load");
        prog.push_back(enc_i(12'h5a5, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        prog.push_back(enc_u(20'habcde, 5'd6, OPC_LUI));
        set_expected(5, sext12(12'h5a5));
        set_expected(6, sext_upper(20'habcde));
        execute_and_check();
    endtask

    task automatic test_alu_ops();
        xlen_t       a;
        xlen_t       b;
        logic [11:0] imm;
        funct3_t     f3;
        logic        alt;
        begin_test("alu_ops");
        add_const(1, a);
        add_const(2, b);
        for (int k = 0; k < 10; k++) begin
            f3  = REG_OPS[k][2:0];
            alt = REG_OPS[k][3];
            prog.push_back(enc_r({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, reg_idx_t'(3 + k)));
            set_expected(3 + k, ref_alu(f3, alt, a, b));
        end
        for (int k = 0; k < 9; k++) begin
            f3  = IMM_OPS[k][2:0];
            alt = IMM_OPS[k][3];
            imm = 12'($urandom);
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, alt, 4'b0, imm[5:0]}; // 6-bit shamt
            end
            prog.push_back(enc_i(imm, 5'd1, f3, reg_idx_t'(13 + k), OPC_OP_IMM));
            set_expected(13 + k, ref_alu(f3, alt, a, sext12(imm)));
        end
        execute_and_check();
    endtask

    task automatic test_upper_and_jumps();
        logic [19:0] u1;
        logic [19:0] u2;
        begin_test("upper_and_jumps");
        u1 = 20'($urandom);
        u2 = 20'($urandom);
        prog.push_back(enc_u(u1, 5'd1, OPC_LUI));
        prog.push_back(enc_u(u2, 5'd2, OPC_AUIPC));
        prog.push_back(enc_j(21'd8, 5'd3));                              // To word 4
        prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd4, OPC_OP_IMM));       // Skipped
        prog.push_back(enc_u(20'd0, 5'd5, OPC_AUIPC));
        prog.push_back(enc_i(12'd13, 5'd5, 3'd0, 5'd6, OPC_JALR));        // 29, bit 0 cleared
        prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd7, OPC_OP_IMM));       // Skipped
        prog.push_back(enc_i(12'd7, 5'd0, 3'd0, 5'd8, OPC_OP_IMM));
        set_expected(1, sext_upper(u1));
        set_expected(2, 64'd4 + sext_upper(u2));
        set_expected(3, 64'd12);
        set_expected(4, 64'd0);
        set_expected(5, 64'd16);
        set_expected(6, 64'd24);
        set_expected(7, 64'd0);
        set_expected(8, 64'd7);
        execute_and_check();
    endtask

    task automatic test_branches();
        xlen_t vals [6];
        int    pa [4];
        int    pb [4];
        int    marker;
        begin_test("branches");
        pa = '{1, 2, 4, 2};
        pb = '{2, 1, 5, 3};
        add_const(1, vals[1]);
        add_const(2, vals[2]);
        prog.push_back(enc_i(12'd0, 5'd2, 3'd0, 5'd3, OPC_OP_IMM));   // Equal pair
        prog.push_back(enc_i(12'hfff, 5'd0, 3'd0, 5'd4, OPC_OP_IMM)); // Sign differs
        prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        vals[3] = vals[2];
        vals[4] = '1;
        vals[5] = 64'd1;
        marker  = 6;
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 4; p++) begin
                prog.push_back(enc_b(13'd8, reg_idx_t'(pa[p]), reg_idx_t'(pb[p]), BR_F3[f]));
                prog.push_back(enc_i(12'd1, 5'd0, 3'd0, reg_idx_t'(marker), OPC_OP_IMM));
                set_expected(marker, ref_taken(BR_F3[f], vals[pa[p]], vals[pb[p]]) ? 0 : 1);
                marker++;
            end
        end
        execute_and_check();
    endtask

    task automatic do_store(int off, int rs2, funct3_t f3, xlen_t data);
        prog.push_back(enc_s(12'(off), reg_idx_t'(rs2), 5'd3, f3));
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            mem_bytes[off + i] = data[8*i +: 8];
        end
    endtask

    task automatic do_load(int rd, int off, funct3_t f3);
        prog.push_back(enc_i(12'(off), 5'd3, f3, reg_idx_t'(rd), OPC_LOAD));
        set_expected(rd, ref_load(off, f3));
    endtask

    task automatic test_load_store();
        xlen_t c1;
        xlen_t c2;
        xlen_t d;
        begin_test("load_store");
        add_const(1, c1);
        add_const(2, c2);
        prog.push_back(enc_i(12'd32, 5'd1, 3'd1, 5'd1, OPC_OP_IMM));    // slli x1, 32
        prog.push_back(enc_r(7'd0, 5'd2, 5'd1, 3'd4, 5'd1));            // Full 64-bit pattern
        prog.push_back(enc_i(12'h100, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));   // Base address
        d = (c1 << 32) ^ c2;
        set_expected(1, d);
        set_expected(2, c2);
        set_expected(3, 64'h100);
        do_store(0, 1, 3'd3, d);
        do_store(8, 1, 3'd3, d);
        do_store(8, 2, 3'd0, c2);
        do_store(10, 2, 3'd1, c2);
        do_store(12, 2, 3'd2, c2);
        do_load(4, 0, 3'd3);
        do_load(5, 4, 3'd2);
        do_load(6, 4, 3'd6);
        do_load(7, 2, 3'd1);
        do_load(8, 6, 3'd5);
        do_load(9, 7, 3'd0);
        do_load(10, 3, 3'd4);
        do_load(11, 8, 3'd3);
        do_load(12, 9, 3'd4);
        do_load(13, 10, 3'd1);
        do_load(14, 12, 3'd6);
        do_load(15, 13, 3'd0);
        execute_and_check();
    endtask

    task automatic test_halt_and_x0();
        begin_test("halt_and_x0");
        prog.push_back(enc_i(12'd5, 5'd0, 3'd0, 5'd0, OPC_OP_IMM));
        prog.push_back(enc_u(20'h12345, 5'd0, OPC_LUI));
        prog.push_back(enc_i(12'd3, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        prog.push_back(enc_j(21'd4, 5'd0));                         // Link to x0 dropped
        prog.push_back(enc_i(12'd1, 5'd1, 3'd0, 5'd2, OPC_OP_IMM));
        set_expected(0, 64'd0);
        set_expected(1, 64'd3);
        set_expected(2, 64'd4);
        execute_and_check();
        run = 1'b1;
        repeat (3) @(negedge clock);
        check_value("pc held after halt", xlen_t'(4 * prog.size()), pc);
        if (!halted) begin
            fail_plain("halted dropped while run stayed high");
        end
        run = 1'b0;
    endtask

    initial begin
        void'($urandom(19536));
        reset_n   = 1'b0;
        run       = 1'b0;
        load_req  = 1'b0;
        load_addr = '0;
        load_word = '0;
        dbg_reg   = '0;
        errors    = 0;
        test_program_load();
        test_alu_ops();
        test_upper_and_jumps();
        test_branches();
        test_load_store();
        test_halt_and_x0();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
rv_pkg.sv
fetch_unit.sv
instr_decoder.sv
reg_file.sv
alu.sv
branch_unit.sv
load_store_unit.sv
rv_core_top.sv
tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f compile.f
./obj_dir/Vtb_rv_core | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
